// ==== hdl/crc_pkg.sv ====
`default_nettype none

package crc_pkg;

	// frame byte and crc widths.
	typedef logic [7:0] byte_t;
	typedef logic [4:0] crc5_t;
	typedef logic [2:0] bit_cnt_t;

	localparam int BITS_PER_BYTE = 8;

	// all ones start value.
	localparam crc5_t CRC_SEED = 5'b11111;

	// x^5 + x^2 + 1 in reflected form, feedback lands in bits 4 and 2.
	localparam crc5_t CRC_FB_MASK = 5'b10100;

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_SHIFT,
		ST_DONE
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

	typedef logic [1:0] wb_adr_t;
	typedef logic [15:0] wb_dat_t;

	// register map, word addresses.
	localparam wb_adr_t ADR_DATA = 2'd0;
	localparam wb_adr_t ADR_FINISH = 2'd1;
	localparam wb_adr_t ADR_RESULT = 2'd2;
	localparam wb_adr_t ADR_STATUS = 2'd3;

	// field positions.
	localparam int RESULT_VALID_BIT = 15;
	localparam int STATUS_BUSY_BIT = 0;

endpackage

`default_nettype wire

// ==== hdl/crc_frame_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_frame_ctrl
(
	input logic i_sys_clk,
	input logic i_sys_rst,
	input logic i_byte_req,
	input logic i_fin_req,
	input logic i_cnt_last,
	output logic o_byte_take,
	output logic o_fin_take,
	output logic o_load,
	output logic o_shift,
	output logic o_reseed,
	output logic o_cnt_clr,
	output logic o_cnt_step,
	output logic o_busy,
	output logic o_done
);

	crc_pkg::ctrl_state_t state;
	crc_pkg::ctrl_state_t state_nxt;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			state <= crc_pkg::ST_IDLE;
		else
			state <= state_nxt;
	end

	// bytes win over a pending finish.
	always_comb
	begin
		state_nxt = state;
		case (state)
			crc_pkg::ST_IDLE:
			begin
				if (i_byte_req)
					state_nxt = crc_pkg::ST_SHIFT;
				else if (i_fin_req)
					state_nxt = crc_pkg::ST_DONE;
			end
			crc_pkg::ST_SHIFT:
			begin
				if (i_cnt_last)
					state_nxt = crc_pkg::ST_IDLE;
			end
			default:
				state_nxt = crc_pkg::ST_IDLE;
		endcase
	end

	assign o_byte_take = (state == crc_pkg::ST_IDLE) && i_byte_req;
	assign o_fin_take = (state == crc_pkg::ST_IDLE) && i_fin_req && !i_byte_req;
	assign o_load = o_byte_take;
	assign o_cnt_clr = o_byte_take;
	assign o_shift = (state == crc_pkg::ST_SHIFT);
	assign o_cnt_step = o_shift;
	assign o_busy = (state != crc_pkg::ST_IDLE);
	assign o_done = (state == crc_pkg::ST_DONE);
	// engine goes back to seed as the frame closes.
	assign o_reseed = o_done;

	// a taken byte is shifted for exactly eight cycles.
	a_eight_shifts: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_byte_take |=> o_shift ##1 o_shift ##1 o_shift ##1 o_shift
			##1 o_shift ##1 o_shift ##1 o_shift ##1 o_shift ##1 !o_shift);

	// a taken finish closes the frame in one cycle.
	a_fin_done: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_fin_take |=> o_done ##1 !o_done);

endmodule

`default_nettype wire

// ==== hdl/crc_bit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_bit_counter
(
	input logic i_sys_clk,
	input logic i_sys_rst,
	input logic i_clr,
	input logic i_step,
	output crc_pkg::bit_cnt_t o_cnt,
	output logic o_cnt_last
);

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			o_cnt <= '0;
		else if (i_clr)
			o_cnt <= '0;
		else if (i_step)
			o_cnt <= o_cnt + crc_pkg::bit_cnt_t'(1);
	end

	assign o_cnt_last = (o_cnt == crc_pkg::bit_cnt_t'(crc_pkg::BITS_PER_BYTE - 1));

	// last step of a byte rolls over.
	a_wrap: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(i_step && !i_clr && o_cnt_last) |=> (o_cnt == '0));

endmodule

`default_nettype wire

// ==== hdl/crc5_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc5_engine
(
	input logic i_sys_clk,
	input logic i_sys_rst,
	input logic i_load,
	input crc_pkg::byte_t i_byte,
	input logic i_shift,
	input crc_pkg::bit_cnt_t i_cnt,
	input logic i_reseed,
	output crc_pkg::crc5_t o_crc
);

	crc_pkg::byte_t byte_q;
	crc_pkg::bit_cnt_t bit_sel;
	logic fb;

	always_ff @(posedge i_sys_clk)
	begin
		if (i_load)
			byte_q <= i_byte;
	end

	// msb first.
	assign bit_sel = crc_pkg::bit_cnt_t'(crc_pkg::BITS_PER_BYTE - 1) - i_cnt;
	assign fb = byte_q[bit_sel] ^ o_crc[0];

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			o_crc <= crc_pkg::CRC_SEED;
		else if (i_reseed)
			o_crc <= crc_pkg::CRC_SEED;
		else if (i_shift)
		begin
			if (fb)
				o_crc <= (o_crc >> 1) ^ crc_pkg::CRC_FB_MASK;
			else
				o_crc <= o_crc >> 1;
		end
	end

	// a new byte only arrives between shift runs.
	a_load_shift: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		!(i_load && i_shift));

endmodule

`default_nettype wire

// ==== hdl/crc_wb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_wb_regs
(
	input logic i_sys_clk,
	input logic i_sys_rst,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input wb_pkg::wb_adr_t i_wb_adr,
	input wb_pkg::wb_dat_t i_wb_dat,
	output wb_pkg::wb_dat_t o_wb_dat,
	output logic o_wb_ack,
	input logic i_byte_take,
	input logic i_fin_take,
	input logic i_busy,
	input logic i_done,
	input crc_pkg::crc5_t i_crc,
	output logic o_byte_req,
	output crc_pkg::byte_t o_byte,
	output logic o_fin_req,
	output crc_pkg::crc5_t o_crc_value,
	output logic o_crc_valid
);

	logic bus_req;
	logic wr_cmd;
	logic wr_data;
	logic wr_fin;
	logic plain_acc;
	logic rd_result;
	crc_pkg::crc5_t result_q;
	logic result_vld;
	wb_pkg::wb_dat_t rd_data;

	assign bus_req = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign wr_cmd = i_wb_we && (i_wb_adr == wb_pkg::ADR_DATA || i_wb_adr == wb_pkg::ADR_FINISH);
	assign wr_data = bus_req && i_wb_we && (i_wb_adr == wb_pkg::ADR_DATA) && !o_byte_req;
	assign wr_fin = bus_req && i_wb_we && (i_wb_adr == wb_pkg::ADR_FINISH) && !o_fin_req;
	// everything else acks on the next edge.
	assign plain_acc = bus_req && !wr_cmd;
	assign rd_result = plain_acc && !i_wb_we && (i_wb_adr == wb_pkg::ADR_RESULT);

	always_comb
	begin
		rd_data = '0;
		if (i_wb_adr == wb_pkg::ADR_RESULT)
		begin
			rd_data[$bits(crc_pkg::crc5_t)-1:0] = result_q;
			rd_data[wb_pkg::RESULT_VALID_BIT] = result_vld;
		end
		else if (i_wb_adr == wb_pkg::ADR_STATUS)
			rd_data[wb_pkg::STATUS_BUSY_BIT] = i_busy;
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			o_wb_ack <= 1'b0;
			o_byte_req <= 1'b0;
			o_fin_req <= 1'b0;
			result_q <= '0;
			result_vld <= 1'b0;
		end
		else
		begin
			// command writes ack when the control takes them.
			o_wb_ack <= i_byte_take || i_fin_take || plain_acc;
			if (wr_data)
				o_byte_req <= 1'b1;
			else if (i_byte_take)
				o_byte_req <= 1'b0;
			if (wr_fin)
				o_fin_req <= 1'b1;
			else if (i_fin_take)
				o_fin_req <= 1'b0;
			if (i_done)
				result_q <= i_crc;
			if (i_done)
				result_vld <= 1'b1;
			else if (rd_result)
				result_vld <= 1'b0;
		end
	end

	always_ff @(posedge i_sys_clk)
	begin
		if (wr_data)
			o_byte <= i_wb_dat[$bits(crc_pkg::byte_t)-1:0];
		if (plain_acc)
			o_wb_dat <= rd_data;
	end

	// the final crc is shown while the frame closes.
	assign o_crc_valid = i_done;
	assign o_crc_value = i_done ? i_crc : result_q;

	a_ack_stb: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_wb_ack |-> i_wb_stb);

endmodule

`default_nettype wire

// ==== hdl/crc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_top
(
	input logic i_sys_clk,
	input logic i_sys_rst,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input wb_pkg::wb_adr_t i_wb_adr,
	input wb_pkg::wb_dat_t i_wb_dat,
	output wb_pkg::wb_dat_t o_wb_dat,
	output logic o_wb_ack,
	output crc_pkg::crc5_t o_crc_value,
	output logic o_crc_valid
);

	logic byte_req;
	logic fin_req;
	logic byte_take;
	logic fin_take;
	logic load;
	logic shift;
	logic reseed;
	logic cnt_clr;
	logic cnt_step;
	logic cnt_last;
	logic busy;
	logic done;
	crc_pkg::byte_t byte_val;
	crc_pkg::bit_cnt_t cnt;
	crc_pkg::crc5_t crc;

	crc_wb_regs regs_i
	(
		.i_sys_clk(i_sys_clk),
		.i_sys_rst(i_sys_rst),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat),
		.o_wb_ack(o_wb_ack),
		.i_byte_take(byte_take),
		.i_fin_take(fin_take),
		.i_busy(busy),
		.i_done(done),
		.i_crc(crc),
		.o_byte_req(byte_req),
		.o_byte(byte_val),
		.o_fin_req(fin_req),
		.o_crc_value(o_crc_value),
		.o_crc_valid(o_crc_valid)
	);

	crc_frame_ctrl ctrl_i
	(
		.i_sys_clk(i_sys_clk),
		.i_sys_rst(i_sys_rst),
		.i_byte_req(byte_req),
		.i_fin_req(fin_req),
		.i_cnt_last(cnt_last),
		.o_byte_take(byte_take),
		.o_fin_take(fin_take),
		.o_load(load),
		.o_shift(shift),
		.o_reseed(reseed),
		.o_cnt_clr(cnt_clr),
		.o_cnt_step(cnt_step),
		.o_busy(busy),
		.o_done(done)
	);

	crc_bit_counter cnt_i
	(
		.i_sys_clk(i_sys_clk),
		.i_sys_rst(i_sys_rst),
		.i_clr(cnt_clr),
		.i_step(cnt_step),
		.o_cnt(cnt),
		.o_cnt_last(cnt_last)
	);

	crc5_engine engine_i
	(
		.i_sys_clk(i_sys_clk),
		.i_sys_rst(i_sys_rst),
		.i_load(load),
		.i_byte(byte_val),
		.i_shift(shift),
		.i_cnt(cnt),
		.i_reseed(reseed),
		.o_crc(crc)
	);

endmodule

`default_nettype wire

// ==== test/crc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_tb;

	localparam int ACK_TIMEOUT = 64;

	logic i_sys_clk;
	logic i_sys_rst;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	wb_pkg::wb_adr_t i_wb_adr;
	wb_pkg::wb_dat_t i_wb_dat;
	wb_pkg::wb_dat_t o_wb_dat;
	logic o_wb_ack;
	crc_pkg::crc5_t o_crc_value;
	logic o_crc_valid;

	int errors = 0;
	int reported = 0;
	int tests = 0;
	int valid_pulses = 0;
	logic engine_busy = 1'b0;
	logic ack_valid;
	crc_pkg::crc5_t ack_crc;
	logic [15:0] lfsr = 16'd99;

	crc_top dut_i
	(
		.i_sys_clk(i_sys_clk),
		.i_sys_rst(i_sys_rst),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat),
		.o_wb_ack(o_wb_ack),
		.o_crc_value(o_crc_value),
		.o_crc_valid(o_crc_valid)
	);

	initial
	begin
		i_sys_clk = 1'b0;
		forever #4 i_sys_clk = ~i_sys_clk;
	end

	always @(negedge i_sys_clk)
	begin
		if (o_crc_valid)
			valid_pulses++;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	// one lfsr step per bit.
	task automatic random_byte(output crc_pkg::byte_t b);
		b = '0;
		for (int k = 0; k < 8; k++)
		begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// x^5 + x^2 + 1, msb of the byte first.
	function automatic crc_pkg::crc5_t model_byte(input crc_pkg::crc5_t c, input crc_pkg::byte_t b);
		crc_pkg::crc5_t r;
		r = c;
		for (int k = 7; k >= 0; k--)
		begin
			if (b[k] ^ r[0])
				r = (r >> 1) ^ 5'b10100;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	task automatic check_crc(input string name, input crc_pkg::crc5_t got, input crc_pkg::crc5_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input wb_pkg::wb_dat_t got, input wb_pkg::wb_dat_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic bus_access(input logic we, input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat,
		output wb_pkg::wb_dat_t rdata, output int waits);
		waits = 0;
		@(posedge i_sys_clk);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we <= we;
		i_wb_adr <= adr;
		i_wb_dat <= dat;
		@(negedge i_sys_clk);
		while (!o_wb_ack && waits < ACK_TIMEOUT)
		begin
			waits++;
			@(negedge i_sys_clk);
		end
		if (!o_wb_ack)
		begin
			$display("no ack within %0d cycles for address %0d", ACK_TIMEOUT, adr);
			$display("test failed");
			$finish;
		end
		else
		begin
			rdata = o_wb_dat;
			ack_valid = o_crc_valid;
			ack_crc = o_crc_value;
			@(posedge i_sys_clk);
			i_wb_cyc <= 1'b0;
			i_wb_stb <= 1'b0;
			i_wb_we <= 1'b0;
		end
	endtask

	task automatic read_reg(input wb_pkg::wb_adr_t adr, output wb_pkg::wb_dat_t rdata);
		int waits;
		bus_access(1'b0, adr, '0, rdata, waits);
		if (waits != 1)
		begin
			errors++;
			$display("read of address %0d took %0d cycles to ack", adr, waits);
		end
	endtask

	// writes that meet a shifting engine must be held off.
	task automatic write_reg(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat);
		wb_pkg::wb_dat_t unused;
		int waits;
		bus_access(1'b1, adr, dat, unused, waits);
		if (engine_busy ? (waits <= 2) : (waits != 2))
		begin
			errors++;
			$display("write to address %0d acked after %0d cycles, engine busy %0d",
				adr, waits, engine_busy);
		end
	endtask

	task automatic end_test(input string what);
		tests++;
		$display("%s: %0d errors", what, errors - reported);
		reported = errors;
	endtask

	task automatic close_frame(input crc_pkg::crc5_t exp);
		wb_pkg::wb_dat_t rdata;
		int pulses_before;
		pulses_before = valid_pulses;
		write_reg(wb_pkg::ADR_FINISH, 16'h0000);
		engine_busy = 1'b0;
		if (!ack_valid)
		begin
			errors++;
			$display("o_crc_valid was low in the FINISH ack cycle");
		end
		check_crc("o_crc_value", ack_crc, exp);
		read_reg(wb_pkg::ADR_STATUS, rdata);
		check_word("STATUS", rdata, 16'h0000);
		read_reg(wb_pkg::ADR_RESULT, rdata);
		check_word("RESULT", rdata, {1'b1, 10'd0, exp});
		read_reg(wb_pkg::ADR_RESULT, rdata);
		check_word("RESULT", rdata, {1'b0, 10'd0, exp});
		if (valid_pulses != pulses_before + 1)
		begin
			errors++;
			$display("o_crc_valid pulsed %0d times for one frame", valid_pulses - pulses_before);
		end
		end_test($sformatf("frame %0d crc %h", tests, exp));
	endtask

	task automatic random_frame(input int len);
		crc_pkg::byte_t b;
		crc_pkg::crc5_t model;
		wb_pkg::wb_dat_t rdata;
		model = crc_pkg::CRC_SEED;
		for (int i = 0; i < len; i++)
		begin
			random_byte(b);
			model = model_byte(model, b);
			write_reg(wb_pkg::ADR_DATA, {8'h00, b});
			engine_busy = 1'b1;
			if (i == 0)
			begin
				read_reg(wb_pkg::ADR_STATUS, rdata);
				check_word("STATUS", rdata, 16'h0001);
			end
		end
		close_frame(model);
	endtask

	initial
	begin
		int fd;
		int n;
		logic [7:0] op;
		logic [15:0] val;
		logic [8*256-1:0] skip;
		wb_pkg::wb_dat_t rdata;
		i_sys_rst = 1'b0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		repeat (5) @(posedge i_sys_clk);
		i_sys_rst <= 1'b1;

		read_reg(wb_pkg::ADR_STATUS, rdata);
		check_word("STATUS", rdata, 16'h0000);
		read_reg(wb_pkg::ADR_RESULT, rdata);
		check_word("RESULT valid flag", rdata & 16'h8000, 16'h0000);
		if (valid_pulses != 0)
		begin
			errors++;
			$display("o_crc_valid pulsed after reset with no frame");
		end
		end_test("reset state");

		fd = $fopen("test/crc_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open test/crc_patterns.txt");
			$display("test failed");
			$finish;
		end
		else
		begin
			while ($fscanf(fd, " %c", op) == 1)
			begin
				if (op == "#")
					n = $fgets(skip, fd);
				else
				begin
					n = $fscanf(fd, " %h", val);
					if (n != 1)
					begin
						errors++;
						$display("op %c has no value in the pattern file", op);
					end
					else
					begin
						case (op)
							"W":
							begin
								write_reg(wb_pkg::ADR_DATA, {8'h00, val[7:0]});
								engine_busy = 1'b1;
							end
							"F":
								close_frame(val[4:0]);
							"R":
								random_frame(int'(val));
							default:
							begin
								errors++;
								$display("unknown op %c in the pattern file", op);
							end
						endcase
					end
				end
			end
			$fclose(fd);

			$display("%0d tests run, %0d errors", tests, errors);
			if (errors == 0)
				$display("test passed");
			else
				$display("test failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== test/crc_patterns.txt ====
# op value: W writes a byte, F finishes with the expected crc, R runs a random frame of n bytes
# all values in hex
W 00
F 1E
W FF
F 1B
W 12
W 34
F 01
W 80
W 00
F 16
R 03
R 01
R 06
R 02

// ==== files.f ====
hdl/crc_pkg.sv
hdl/wb_pkg.sv
hdl/crc_frame_ctrl.sv
hdl/crc_bit_counter.sv
hdl/crc5_engine.sv
hdl/crc_wb_regs.sv
hdl/crc_top.sv
test/crc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the CRC-5 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module crc_tb -o crc_sim
./obj_dir/crc_sim | tee sim.log

if grep -qx "test passed" sim.log; then
	exit 0
else
	echo "simulation did not report a pass"
	exit 1
fi
